// ==== rtl/alu_pkg.sv ====
package alu_pkg;

    // ----------------------------------------------------------
    // Datapath dimensions
    // ----------------------------------------------------------

    // Register width of the core
    localparam int unsigned XLEN = 64;

    // Shift amount taken from the low bits of operand b
    localparam int unsigned SHAMT_W = 6;

    // ----------------------------------------------------------
    // Operator encoding
    // ----------------------------------------------------------

    typedef enum logic [5:0] {
        // Adder
        ADD,
        SUB,
        // Logic, the n forms use the inverted operand b
        ANDL,
        ORL,
        XORL,
        ANDN,
        ORN,
        XNOR,
        // Shifts
        SLL,
        SRL,
        SRA,
        // Set less than
        SLTS,
        SLTU,
        // Branch comparisons
        EQ,
        NE,
        LTS,
        LTU,
        GES,
        GEU,
        // Packed byte ops for polar decoding
        P_MIN,
        P_SUBSAT,
        P_ADDSAT,
        P_ADDSATMIN,
        P_HMIN,
        P_IDXMINCOMP,
        P_IDXMINUP,
        P_IDXMINUP2,
        P_IDXCOMPV3
    } alu_op_e;

endpackage

// ==== rtl/polar_pkg.sv ====
package polar_pkg;

    // Width of one packed lane
    localparam int unsigned LANE_W = 8;

    // Lanes in a 64 bit operand
    localparam int unsigned LANES = 8;

    // One extra bit so a lane sum or difference cannot wrap
    localparam int unsigned SUM_W = 9;

    // Upper clamp for saturating lane arithmetic
    localparam logic signed [SUM_W-1:0] SAT_MAX = 9'sd63;

    // Lanes of operand a seen by the horizontal minimum
    localparam int unsigned HMIN_LANES = 4;

endpackage

// ==== rtl/alu_adder.sv ====
`timescale 1ns/100ps

module alu_adder (
    input  alu_pkg::alu_op_e          op_i,
    input  logic [alu_pkg::XLEN-1:0]  operand_a_i,
    input  logic [alu_pkg::XLEN-1:0]  operand_b_i,
    output logic [alu_pkg::XLEN-1:0]  operand_b_neg_o,
    output logic [alu_pkg::XLEN-1:0]  sum_o,
    output logic                      less_o,
    output logic                      branch_o
);

    logic                    b_negate;
    logic [alu_pkg::XLEN:0]  adder_in_a;
    logic [alu_pkg::XLEN:0]  adder_in_b;
    logic [alu_pkg::XLEN:0]  adder_sum_ext;
    logic                    zero_flag;
    logic                    cmp_signed;

    // Operators that need ~b
    always_comb begin
        b_negate = 1'b0;
        unique case (op_i)
            alu_pkg::SUB,
            alu_pkg::EQ,  alu_pkg::NE,
            alu_pkg::ANDN, alu_pkg::ORN, alu_pkg::XNOR: b_negate = 1'b1;
            default: b_negate = 1'b0;
        endcase
    end

    // ----------------------------------------------------------
    // Adder with carry in on the extra low bit
    // ----------------------------------------------------------

    // The low bit of a is 1 and of ~b is 1, so the carry into bit 1 is b_negate
    assign adder_in_a    = {operand_a_i, 1'b1};
    assign adder_in_b    = {operand_b_i, 1'b0} ^ {(alu_pkg::XLEN+1){b_negate}};
    assign adder_sum_ext = adder_in_a + adder_in_b;

    assign operand_b_neg_o = adder_in_b[alu_pkg::XLEN:1];
    assign sum_o           = adder_sum_ext[alu_pkg::XLEN:1];
    assign zero_flag       = ~|sum_o;

    // ----------------------------------------------------------
    // Less than, signed or unsigned
    // ----------------------------------------------------------

    assign cmp_signed = (op_i == alu_pkg::SLTS) ||
                        (op_i == alu_pkg::LTS)  ||
                        (op_i == alu_pkg::GES);

    // One signed compare, the sign bit is zeroed for unsigned forms
    assign less_o = $signed({cmp_signed & operand_a_i[alu_pkg::XLEN-1], operand_a_i}) <
                    $signed({cmp_signed & operand_b_i[alu_pkg::XLEN-1], operand_b_i});

    // Branch outcome, taken by default
    always_comb begin
        unique case (op_i)
            alu_pkg::EQ:               branch_o = zero_flag;
            alu_pkg::NE:               branch_o = ~zero_flag;
            alu_pkg::LTS, alu_pkg::LTU: branch_o = less_o;
            alu_pkg::GES, alu_pkg::GEU: branch_o = ~less_o;
            default:                   branch_o = 1'b1;
        endcase
    end

endmodule

// ==== rtl/alu_shifter.sv ====
`timescale 1ns/100ps

module alu_shifter (
    input  alu_pkg::alu_op_e            op_i,
    input  logic [alu_pkg::XLEN-1:0]    operand_a_i,
    input  logic [alu_pkg::SHAMT_W-1:0] shamt_i,
    output logic [alu_pkg::XLEN-1:0]    shift_o
);

    logic                     shift_left;
    logic                     shift_arith;
    logic [alu_pkg::XLEN-1:0] operand_a_rev;
    logic [alu_pkg::XLEN-1:0] shift_in;
    logic [alu_pkg::XLEN:0]   shift_in_ext;
    logic [alu_pkg::XLEN:0]   right_result;
    logic [alu_pkg::XLEN-1:0] left_result;

    assign shift_left  = (op_i == alu_pkg::SLL);
    assign shift_arith = (op_i == alu_pkg::SRA);

    // Left shift is a right shift of the reversed operand
    for (genvar k = 0; k < alu_pkg::XLEN; k++) begin : g_rev
        assign operand_a_rev[k] = operand_a_i[alu_pkg::XLEN-1-k];
        assign left_result[k]   = right_result[alu_pkg::XLEN-1-k];
    end

    assign shift_in = shift_left ? operand_a_rev : operand_a_i;

    // Extra top bit carries the sign only for SRA
    assign shift_in_ext = {shift_arith & shift_in[alu_pkg::XLEN-1], shift_in};

    // The one shifter shared by all three shifts
    assign right_result = $unsigned($signed(shift_in_ext) >>> shamt_i);

    assign shift_o = shift_left ? left_result : right_result[alu_pkg::XLEN-1:0];

    // ----------------------------------------------------------
    // Checks
    // ----------------------------------------------------------

    // Sign must survive extension, shift and the output select
    always_comb begin
        assert final (!((op_i == alu_pkg::SRA) && operand_a_i[alu_pkg::XLEN-1] &&
                        (shamt_i < alu_pkg::XLEN)) || shift_o[alu_pkg::XLEN-1])
        else $error("SRA of a negative operand lost the sign bit");
    end

endmodule

// ==== rtl/alu_polar_simd.sv ====
`timescale 1ns/100ps

module alu_polar_simd (
    input  alu_pkg::alu_op_e          op_i,
    input  logic [alu_pkg::XLEN-1:0]  operand_a_i,
    input  logic [alu_pkg::XLEN-1:0]  operand_b_i,
    input  logic [alu_pkg::XLEN-1:0]  imm_i,
    output logic [alu_pkg::XLEN-1:0]  simd_o
);

    logic [alu_pkg::XLEN-1:0]        r_min;
    logic [alu_pkg::XLEN-1:0]        r_subsat;
    logic [alu_pkg::XLEN-1:0]        r_addsat;
    logic [alu_pkg::XLEN-1:0]        r_addsatmin;
    logic [alu_pkg::XLEN-1:0]        r_idxmincomp;
    logic [alu_pkg::XLEN-1:0]        r_idxminup;
    logic [alu_pkg::XLEN-1:0]        r_idxminup2;
    logic [alu_pkg::XLEN-1:0]        r_idxcompv3;
    logic [polar_pkg::LANE_W-1:0]    hmin;

    // ----------------------------------------------------------
    // Per lane datapath
    // ----------------------------------------------------------

    for (genvar i = 0; i < polar_pkg::LANES; i++) begin : g_lane
        logic signed [polar_pkg::LANE_W-1:0] a_l;
        logic signed [polar_pkg::LANE_W-1:0] b_l;
        logic        [polar_pkg::LANE_W-1:0] imm_l;
        logic signed [polar_pkg::SUM_W-1:0]  diff;
        logic signed [polar_pkg::SUM_W-1:0]  sum;
        logic                                a_ge_b;

        assign a_l   = operand_a_i[i*polar_pkg::LANE_W +: polar_pkg::LANE_W];
        assign b_l   = operand_b_i[i*polar_pkg::LANE_W +: polar_pkg::LANE_W];
        assign imm_l = imm_i[i*polar_pkg::LANE_W +: polar_pkg::LANE_W];

        // Sign extended to SUM_W before the arithmetic
        assign diff   = polar_pkg::SUM_W'(a_l) - polar_pkg::SUM_W'(b_l);
        assign sum    = polar_pkg::SUM_W'(a_l) + polar_pkg::SUM_W'(b_l);
        assign a_ge_b = (a_l >= b_l);

        assign r_min[i*polar_pkg::LANE_W +: polar_pkg::LANE_W] = a_ge_b ? b_l : a_l;

        // Upper clamp only, negative results just wrap to 8 bits
        assign r_subsat[i*polar_pkg::LANE_W +: polar_pkg::LANE_W] =
            (diff > polar_pkg::SAT_MAX) ? polar_pkg::SAT_MAX[polar_pkg::LANE_W-1:0]
                                        : diff[polar_pkg::LANE_W-1:0];
        assign r_addsat[i*polar_pkg::LANE_W +: polar_pkg::LANE_W] =
            (sum > polar_pkg::SAT_MAX) ? polar_pkg::SAT_MAX[polar_pkg::LANE_W-1:0]
                                       : sum[polar_pkg::LANE_W-1:0];

        // Unsigned compare against the imm lane
        assign r_addsatmin[i*polar_pkg::LANE_W +: polar_pkg::LANE_W] =
            (r_addsat[i*polar_pkg::LANE_W +: polar_pkg::LANE_W] > imm_l) ? imm_l
            : r_addsat[i*polar_pkg::LANE_W +: polar_pkg::LANE_W];

        assign r_idxmincomp[i*polar_pkg::LANE_W +: polar_pkg::LANE_W] =
            a_ge_b ? 8'hff : 8'h00;
        assign r_idxminup[i*polar_pkg::LANE_W +: polar_pkg::LANE_W] =
            a_l & operand_b_i[polar_pkg::LANE_W-1:0];
        assign r_idxminup2[i*polar_pkg::LANE_W +: polar_pkg::LANE_W] = a_ge_b ? a_l : b_l;
        assign r_idxcompv3[i*polar_pkg::LANE_W +: polar_pkg::LANE_W] =
            a_ge_b ? imm_i[polar_pkg::LANE_W-1:0] : 8'h00;
    end

    // Horizontal min, seeded with byte 0 of b
    always_comb begin
        hmin = operand_b_i[polar_pkg::LANE_W-1:0];
        for (int i = 0; i < polar_pkg::HMIN_LANES; i++) begin
            if (operand_a_i[i*polar_pkg::LANE_W +: polar_pkg::LANE_W] < hmin) begin
                hmin = operand_a_i[i*polar_pkg::LANE_W +: polar_pkg::LANE_W];
            end
        end
    end

    always_comb begin
        unique case (op_i)
            alu_pkg::P_MIN:        simd_o = r_min;
            alu_pkg::P_SUBSAT:     simd_o = r_subsat;
            alu_pkg::P_ADDSAT:     simd_o = r_addsat;
            alu_pkg::P_ADDSATMIN:  simd_o = r_addsatmin;
            alu_pkg::P_HMIN:       simd_o = {{(alu_pkg::XLEN-polar_pkg::LANE_W){1'b0}}, hmin};
            alu_pkg::P_IDXMINCOMP: simd_o = r_idxmincomp;
            alu_pkg::P_IDXMINUP:   simd_o = r_idxminup;
            alu_pkg::P_IDXMINUP2:  simd_o = r_idxminup2;
            alu_pkg::P_IDXCOMPV3:  simd_o = r_idxcompv3;
            default:               simd_o = '0;
        endcase
    end

endmodule

// ==== rtl/alu_top.sv ====
`timescale 1ns/100ps

module alu_top (
    input  logic                      clk_i,
    input  logic                      arst_n_i,
    // Request
    input  logic                      valid_i,
    output logic                      ready_o,
    input  alu_pkg::alu_op_e          op_i,
    input  logic [alu_pkg::XLEN-1:0]  operand_a_i,
    input  logic [alu_pkg::XLEN-1:0]  operand_b_i,
    input  logic [alu_pkg::XLEN-1:0]  imm_i,
    // Response
    output logic                      valid_o,
    input  logic                      ready_i,
    output logic [alu_pkg::XLEN-1:0]  result_o,
    output logic                      branch_o
);

    logic [alu_pkg::XLEN-1:0] operand_b_neg;
    logic [alu_pkg::XLEN-1:0] sum;
    logic [alu_pkg::XLEN-1:0] shift_result;
    logic [alu_pkg::XLEN-1:0] simd_result;
    logic [alu_pkg::XLEN-1:0] result_d;
    logic                     less;
    logic                     branch_d;
    logic                     accept;

    alu_adder i_alu_adder (
        .op_i            (op_i),
        .operand_a_i     (operand_a_i),
        .operand_b_i     (operand_b_i),
        .operand_b_neg_o (operand_b_neg),
        .sum_o           (sum),
        .less_o          (less),
        .branch_o        (branch_d)
    );

    alu_shifter i_alu_shifter (
        .op_i        (op_i),
        .operand_a_i (operand_a_i),
        .shamt_i     (operand_b_i[alu_pkg::SHAMT_W-1:0]),
        .shift_o     (shift_result)
    );

    alu_polar_simd i_alu_polar_simd (
        .op_i        (op_i),
        .operand_a_i (operand_a_i),
        .operand_b_i (operand_b_i),
        .imm_i       (imm_i),
        .simd_o      (simd_result)
    );

    // ----------------------------------------------------------
    // Result select
    // ----------------------------------------------------------

    always_comb begin
        unique case (op_i)
            alu_pkg::ADD,  alu_pkg::SUB:  result_d = sum;
            // Inverted forms reuse the negated b from the adder
            alu_pkg::ANDL, alu_pkg::ANDN: result_d = operand_a_i & operand_b_neg;
            alu_pkg::ORL,  alu_pkg::ORN:  result_d = operand_a_i | operand_b_neg;
            alu_pkg::XORL, alu_pkg::XNOR: result_d = operand_a_i ^ operand_b_neg;
            alu_pkg::SLL, alu_pkg::SRL, alu_pkg::SRA: result_d = shift_result;
            alu_pkg::SLTS, alu_pkg::SLTU: result_d = {{(alu_pkg::XLEN-1){1'b0}}, less};
            alu_pkg::EQ, alu_pkg::NE, alu_pkg::LTS,
            alu_pkg::LTU, alu_pkg::GES, alu_pkg::GEU: result_d = '0;
            default: result_d = simd_result;
        endcase
    end

    // ----------------------------------------------------------
    // Output register with valid/ready
    // ----------------------------------------------------------

    // Free when empty or when the held item leaves this cycle
    assign ready_o = ~valid_o | ready_i;
    assign accept  = valid_i & ready_o;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_o <= 1'b0;
        end else if (ready_o) begin
            valid_o <= valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            result_o <= result_d;
            branch_o <= branch_d;
        end
    end

    // Held response must not move under back-pressure
    assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (valid_o && !ready_i) |=> (valid_o && $stable(result_o) && $stable(branch_o)))
    else $error("Response changed while stalled");

    // Requests carry a defined operator
    assert property (@(posedge clk_i) disable iff (!arst_n_i)
        valid_i |-> (!$isunknown(op_i) && (op_i <= alu_pkg::P_IDXCOMPV3)))
    else $error("Unknown operator on a valid request");

endmodule

// ==== verification/tb_clock_gen.sv ====
`timescale 1ns/100ps

module tb_clock_gen #(
    parameter int unsigned PERIOD_NS = 100
) (
    output logic clk_o
);

    // Free running, starts low
    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

endmodule

// ==== verification/tb_alu_vectors.svh ====
`ifndef TB_ALU_VECTORS_SVH
`define TB_ALU_VECTORS_SVH

// One row per request: operator, a, b, imm, expected result, expected branch
typedef struct packed {
    alu_pkg::alu_op_e         op;
    logic [alu_pkg::XLEN-1:0] a;
    logic [alu_pkg::XLEN-1:0] b;
    logic [alu_pkg::XLEN-1:0] imm;
    logic [alu_pkg::XLEN-1:0] result;
    logic                     branch;
} vector_t;

vector_t vectors[$];

task automatic add_row(
    input alu_pkg::alu_op_e         op,
    input logic [alu_pkg::XLEN-1:0] a,
    input logic [alu_pkg::XLEN-1:0] b,
    input logic [alu_pkg::XLEN-1:0] imm,
    input logic [alu_pkg::XLEN-1:0] result,
    input logic                     branch
);
    vector_t row;
    row = {op, a, b, imm, result, branch};
    vectors.push_back(row);
endtask

task automatic load_vectors();
    logic [alu_pkg::XLEN-1:0] ones;
    logic [alu_pkg::XLEN-1:0] log_a;
    logic [alu_pkg::XLEN-1:0] log_b;
    logic [alu_pkg::XLEN-1:0] sh_a;
    logic [alu_pkg::XLEN-1:0] pa;
    logic [alu_pkg::XLEN-1:0] pb;
    logic [alu_pkg::XLEN-1:0] ma;
    logic [alu_pkg::XLEN-1:0] mb;
    ones  = '1;
    log_a = 64'h00FF00FFF0F01234;
    log_b = 64'h0F0FFFFF000000FF;
    sh_a  = 64'h8000000000000001;
    pa    = 64'h00000080F0107F20;
    pb    = 64'h0000008008050130;
    ma    = 64'h000000008001FE05;
    mb    = 64'h000000007F010103;

    // Adder wrap and set less than
    add_row(alu_pkg::ADD, ones, 64'h1, 64'h0, 64'h0, 1'b1);
    add_row(alu_pkg::SUB, 64'h0, 64'h1, 64'h0, ones, 1'b1);
    add_row(alu_pkg::SLTS, ones, 64'h1, 64'h0, 64'h1, 1'b1);
    add_row(alu_pkg::SLTU, ones, 64'h1, 64'h0, 64'h0, 1'b1);

    // Logic, inverted forms see ~b
    add_row(alu_pkg::ANDL, log_a, log_b, 64'h0, 64'h000F00FF00000034, 1'b1);
    add_row(alu_pkg::ORL,  log_a, log_b, 64'h0, 64'h0FFFFFFFF0F012FF, 1'b1);
    add_row(alu_pkg::XORL, log_a, log_b, 64'h0, 64'h0FF0FF00F0F012CB, 1'b1);
    add_row(alu_pkg::ANDN, log_a, log_b, 64'h0, 64'h00F00000F0F01200, 1'b1);
    add_row(alu_pkg::ORN,  log_a, log_b, 64'h0, 64'hF0FF00FFFFFFFF34, 1'b1);
    add_row(alu_pkg::XNOR, log_a, log_b, 64'h0, 64'hF00F00FF0F0FED34, 1'b1);

    // Shift amounts 0, 1 and 63 from the low 6 bits of b
    add_row(alu_pkg::SLL, sh_a, 64'h100,  64'h0, 64'h8000000000000001, 1'b1);
    add_row(alu_pkg::SLL, sh_a, 64'hFFC1, 64'h0, 64'h0000000000000002, 1'b1);
    add_row(alu_pkg::SLL, sh_a, 64'h3F,   64'h0, 64'h8000000000000000, 1'b1);
    add_row(alu_pkg::SRL, sh_a, 64'h100,  64'h0, 64'h8000000000000001, 1'b1);
    add_row(alu_pkg::SRL, sh_a, 64'hFFC1, 64'h0, 64'h4000000000000000, 1'b1);
    add_row(alu_pkg::SRL, sh_a, 64'h3F,   64'h0, 64'h0000000000000001, 1'b1);
    add_row(alu_pkg::SRA, sh_a, 64'h100,  64'h0, 64'h8000000000000001, 1'b1);
    add_row(alu_pkg::SRA, sh_a, 64'hFFC1, 64'h0, 64'hC000000000000000, 1'b1);
    add_row(alu_pkg::SRA, sh_a, 64'h3F,   64'h0, ones, 1'b1);

    // Branches on equal, less and greater pairs
    add_row(alu_pkg::EQ,  64'h5, 64'h5, 64'h0, 64'h0, 1'b1);
    add_row(alu_pkg::EQ,  64'h1, 64'h2, 64'h0, 64'h0, 1'b0);
    add_row(alu_pkg::EQ,  64'h2, 64'h1, 64'h0, 64'h0, 1'b0);
    add_row(alu_pkg::NE,  64'h5, 64'h5, 64'h0, 64'h0, 1'b0);
    add_row(alu_pkg::NE,  64'h1, 64'h2, 64'h0, 64'h0, 1'b1);
    add_row(alu_pkg::NE,  64'h2, 64'h1, 64'h0, 64'h0, 1'b1);
    add_row(alu_pkg::LTS, 64'h5, 64'h5, 64'h0, 64'h0, 1'b0);
    add_row(alu_pkg::LTS, ones,  64'h1, 64'h0, 64'h0, 1'b1);
    add_row(alu_pkg::LTS, 64'h1, ones,  64'h0, 64'h0, 1'b0);
    add_row(alu_pkg::GES, 64'h5, 64'h5, 64'h0, 64'h0, 1'b1);
    add_row(alu_pkg::GES, ones,  64'h1, 64'h0, 64'h0, 1'b0);
    add_row(alu_pkg::GES, 64'h1, ones,  64'h0, 64'h0, 1'b1);
    add_row(alu_pkg::LTU, 64'h5, 64'h5, 64'h0, 64'h0, 1'b0);
    add_row(alu_pkg::LTU, 64'h1, ones,  64'h0, 64'h0, 1'b1);
    add_row(alu_pkg::LTU, ones,  64'h1, 64'h0, 64'h0, 1'b0);
    add_row(alu_pkg::GEU, 64'h5, 64'h5, 64'h0, 64'h0, 1'b1);
    add_row(alu_pkg::GEU, 64'h1, ones,  64'h0, 64'h0, 1'b0);
    add_row(alu_pkg::GEU, ones,  64'h1, 64'h0, 64'h0, 1'b1);

    // Packed bytes: ceiling, negative wrap and imm clamp
    add_row(alu_pkg::P_ADDSAT, pa, pb, 64'h0, 64'h00000000F8153F3F, 1'b1);
    add_row(alu_pkg::P_SUBSAT, pa, pb, 64'h0, 64'h00000000E80B3FF0, 1'b1);
    add_row(alu_pkg::P_ADDSATMIN, pa, pb, 64'hFFFFFF0080157F10, 64'h0000000080153F10, 1'b1);

    // Each horizontal minimum candidate wins once
    add_row(alu_pkg::P_HMIN, 64'h01010101F0809010, 64'h50, 64'h0, 64'h10, 1'b1);
    add_row(alu_pkg::P_HMIN, 64'h01010101F0800510, 64'h50, 64'h0, 64'h05, 1'b1);
    add_row(alu_pkg::P_HMIN, 64'h01010101F0039010, 64'h50, 64'h0, 64'h03, 1'b1);
    add_row(alu_pkg::P_HMIN, 64'h0101010102809010, 64'h50, 64'h0, 64'h02, 1'b1);
    add_row(alu_pkg::P_HMIN, 64'h01010101F0809010, 64'hFFFFFFFFFFFFFF08, 64'h0, 64'h08, 1'b1);

    // Signed lane compare, both outcomes
    add_row(alu_pkg::P_MIN, ma, mb, 64'h0, 64'h000000008001FE03, 1'b1);
    add_row(alu_pkg::P_IDXMINCOMP, ma, mb, 64'h0, 64'hFFFFFFFF00FF00FF, 1'b1);
    add_row(alu_pkg::P_IDXMINUP2, ma, mb, 64'h0, 64'h000000007F010105, 1'b1);
    add_row(alu_pkg::P_IDXCOMPV3, ma, mb, 64'hFFA5, 64'hA5A5A5A500A500A5, 1'b1);
    add_row(alu_pkg::P_IDXMINUP, 64'h1122334455667788, 64'hFFFFFFFFFFFFFFF0, 64'h0,
            64'h1020304050607080, 1'b1);
endtask

`endif

// ==== verification/tb_alu.sv ====
`timescale 1ns/100ps

module tb_alu;

    localparam int unsigned XLEN           = alu_pkg::XLEN;
    localparam int unsigned RESET_CYCLES   = 5;
    localparam int unsigned DRIVE_DELAY_NS = 10;
    localparam int unsigned MAX_CYCLES     = 1000;
    localparam logic [15:0] LFSR_SEED      = 16'd3;
    localparam logic [15:0] LFSR_TAPS      = 16'hB400;

    logic             clk;
    logic             arst_n;
    logic             req_valid;
    logic             req_ready;
    alu_pkg::alu_op_e req_op;
    logic [XLEN-1:0]  req_a;
    logic [XLEN-1:0]  req_b;
    logic [XLEN-1:0]  req_imm;
    logic             rsp_valid;
    logic             rsp_ready;
    logic [XLEN-1:0]  rsp_result;
    logic             rsp_branch;
    logic [15:0]      lfsr_state;
    // Rows accepted and not yet answered in arrival order
    int               expected_q[$];

    `include "tb_alu_vectors.svh"

    tb_clock_gen #(.PERIOD_NS(100)) i_tb_clock_gen (.clk_o(clk));

    alu_top i_alu_top (
        .clk_i       (clk),
        .arst_n_i    (arst_n),
        .valid_i     (req_valid),
        .ready_o     (req_ready),
        .op_i        (req_op),
        .operand_a_i (req_a),
        .operand_b_i (req_b),
        .imm_i       (req_imm),
        .valid_o     (rsp_valid),
        .ready_i     (rsp_ready),
        .result_o    (rsp_result),
        .branch_o    (rsp_branch)
    );

    // Galois LFSR step that shifts out the random bit
    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        logic [15:0] stepped;
        stepped = state >> 1;
        if (state[0]) begin
            stepped = stepped ^ LFSR_TAPS;
        end
        return stepped;
    endfunction

    task automatic stop_on_error(input string what);
        $display("%s", what);
        $display("Testbench failed");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [XLEN-1:0] got,
                               input logic [XLEN-1:0] exp);
        assert (got === exp)
        else stop_on_error($sformatf("CHECK FAILED %s: got 0x%h, expected 0x%h",
                                     name, got, exp));
    endtask

    // ----------------------------------------------------------
    // One pass over the table with responses matched in order
    // ----------------------------------------------------------

    task automatic run_table(input bit random_ready);
        int unsigned     cycles;
        int              row;
        int              exp_row;
        int              responses;
        logic            occupied;
        logic            exp_ready;
        logic            stalled;
        logic            accepted;
        logic [XLEN-1:0] held_result;
        logic            held_branch;
        cycles      = 0;
        row         = 0;
        responses   = 0;
        occupied    = 1'b0;
        exp_ready   = 1'b0;
        stalled     = 1'b0;
        accepted    = 1'b0;
        held_result = '0;
        held_branch = 1'b0;
        while (responses < vectors.size()) begin
            // Current row stays on the bus until taken
            req_valid = (row < vectors.size());
            if (row < vectors.size()) begin
                req_op  = vectors[row].op;
                req_a   = vectors[row].a;
                req_b   = vectors[row].b;
                req_imm = vectors[row].imm;
            end
            if (random_ready) begin
                rsp_ready  = lfsr_state[0];
                lfsr_state = lfsr_next(lfsr_state);
            end else begin
                rsp_ready = 1'b1;
            end

            // All outputs settled at the falling edge
            @(negedge clk);
            // Free when empty or when the held item leaves
            exp_ready = !occupied || rsp_ready;
            check_value("ready_o", XLEN'(req_ready), XLEN'(exp_ready));
            // Item present from the edge after its accept until it leaves
            check_value("valid_o", XLEN'(rsp_valid), XLEN'(occupied));
            if (stalled) begin
                check_value("result_o", rsp_result, held_result);
                check_value("branch_o", XLEN'(rsp_branch), XLEN'(held_branch));
            end
            if (occupied && rsp_ready) begin
                exp_row = expected_q.pop_front();
                check_value("result_o", rsp_result, vectors[exp_row].result);
                check_value("branch_o", XLEN'(rsp_branch), XLEN'(vectors[exp_row].branch));
                responses++;
            end
            stalled     = occupied && !rsp_ready;
            held_result = rsp_result;
            held_branch = rsp_branch;
            accepted    = req_valid && exp_ready;
            occupied    = accepted || stalled;
            if (accepted) begin
                expected_q.push_back(row);
                row++;
            end

            cycles++;
            assert (cycles < MAX_CYCLES)
            else stop_on_error("Timed out waiting for all responses of the table");
            @(posedge clk);
            #(DRIVE_DELAY_NS);
        end
    endtask

    initial begin
        arst_n     = 1'b0;
        req_valid  = 1'b0;
        req_op     = alu_pkg::ADD;
        req_a      = '0;
        req_b      = '0;
        req_imm    = '0;
        rsp_ready  = 1'b0;
        lfsr_state = LFSR_SEED;
        load_vectors();

        repeat (RESET_CYCLES) @(posedge clk);
        #(DRIVE_DELAY_NS);
        arst_n = 1'b1;
        @(negedge clk);
        check_value("valid_o", XLEN'(rsp_valid), '0);
        @(posedge clk);
        #(DRIVE_DELAY_NS);

        // Random back-pressure first and ready held high after it
        run_table(1'b1);
        run_table(1'b0);

        // Nothing may follow the last response
        req_valid = 1'b0;
        @(negedge clk);
        if (rsp_valid === 1'b0) begin
            $display("Testbench passed");
            $finish;
        end else begin
            stop_on_error($sformatf("CHECK FAILED valid_o: got 0x%h, expected 0x%h",
                                    rsp_valid, 1'b0));
        end
    end

endmodule

// ==== list.f ====
+incdir+verification
rtl/alu_pkg.sv
rtl/polar_pkg.sv
rtl/alu_adder.sv
rtl/alu_shifter.sv
rtl/alu_polar_simd.sv
rtl/alu_top.sv
verification/tb_clock_gen.sv
verification/tb_alu.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the ALU testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f list.f --top-module tb_alu -o tb_alu_sim
if [ $? -ne 0 ]; then
    echo "ERROR: Verilator build failed"
    exit 1
fi

./obj_dir/tb_alu_sim > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "Testbench failed" "$LOG"; then
    echo "RESULT: FAIL"
    exit 1
fi
if [ $run_status -ne 0 ]; then
    echo "RESULT: FAIL (simulator exited with status $run_status)"
    exit 1
fi

echo "RESULT: PASS"
exit 0
